// ==== Makefile ====
TOP := tb_unsat_select

.PHONY: compile run clean

compile:
	verilator --binary --timing --assert -Wno-fatal -f compile.f --top-module $(TOP) -o $(TOP)

run: compile
	@out="$$(./obj_dir/$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "TESTBENCH PASSED"

clean:
	rm -rf obj_dir

// ==== clause_fifo.sv ====
`timescale 1ns/1ps

module clause_fifo (
    input  logic             clk_i,
    input  logic             rst_i,
    input  logic             push_i,       // one-cycle strobe
    input  sat_pkg::clause_t push_data_i,
    input  logic             pop_i,
    output sat_pkg::clause_t head_o,       // oldest clause, no read latency
    output logic             empty_o,
    output logic             full_o
);
    import sat_pkg::*;

    clause_t               mem [FIFO_DEPTH];
    logic [FIFO_PTR_W-1:0] wr_ptr_q;
    logic [FIFO_PTR_W-1:0] rd_ptr_q;
    logic [FIFO_PTR_W:0]   used_q;    // occupancy, 0..FIFO_DEPTH
    logic                  do_push;
    logic                  do_pop;

    assign empty_o = (used_q == '0);
    assign full_o  = (used_q == (FIFO_PTR_W+1)'(FIFO_DEPTH));
    assign do_push = push_i & ~full_o;   // push to full is dropped
    assign do_pop  = pop_i & ~empty_o;
    assign head_o  = mem[rd_ptr_q];

    always_ff @(posedge clk_i) begin
        if (do_push) begin
            mem[wr_ptr_q] <= push_data_i;
        end
    end

    // pointers wrap on their own, depth is a power of two
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            used_q   <= '0;
        end else begin
            if (do_push) begin
                wr_ptr_q <= wr_ptr_q + 1'b1;
            end
            if (do_pop) begin
                rd_ptr_q <= rd_ptr_q + 1'b1;
            end
            case ({do_push, do_pop})
                2'b10:   used_q <= used_q + 1'b1;
                2'b01:   used_q <= used_q - 1'b1;
                default: used_q <= used_q;  // none, or one in and one out
            endcase
        end
    end

    // the selector pops only a head it has seen
    a_no_pop_empty: assert property (@(posedge clk_i) disable iff (rst_i)
        pop_i |-> !empty_o)
        else $error("clause_fifo: pop while empty");

    // the solver must not produce more newly unsat clauses than fit
    a_no_push_full: assert property (@(posedge clk_i) disable iff (rst_i)
        push_i |-> !full_o)
        else $error("clause_fifo: push while full, clause lost");

endmodule

// ==== compile.f ====
sat_pkg.sv
unsat_clause_buffer.sv
recip_table.sv
clause_fifo.sv
unsat_clause_selector.sv
unsat_select_top.sv
tb_unsat_select.sv

// ==== recip_table.sv ====
`timescale 1ns/1ps

module recip_table (
    input  logic                           clk_i,
    input  logic                           rst_i,
    input  logic [sat_pkg::BUF_ADDR_W-1:0] addr_i,        // current count m
    input  logic                           clear_dbg_i,
    output logic [sat_pkg::RECIP_W-1:0]    recip_o,       // ceil(2^RECIP_W / m)
    output logic                           div_by_zero_o  // sticky debug flag
);
    import sat_pkg::*;

    logic [RECIP_W-1:0]            rom [BUF_DEPTH];
    logic [BUF_ADDR_W-1:0]         addr_q;      // m behind recip_o
    logic [RECIP_W+BUF_ADDR_W-1:0] recip_back;  // recip_o * m
    logic                          was_zero_q;  // address was 0 last cycle
    logic                          zero_hit;

    // reciprocals rounded up, so rand*recip never falls short of rand/m
    initial begin : fill_rom
        int                   m;
        logic [2*RECIP_W-1:0] num;
        logic [2*RECIP_W-1:0] den;
        logic [2*RECIP_W-1:0] q;
        num          = '0;
        num[RECIP_W] = 1'b1;  // 2^RECIP_W
        rom[0]       = '0;    // no 1/0
        for (m = 1; m < BUF_DEPTH; m++) begin
            den = (2*RECIP_W)'(m);
            q   = (num + den - 1'b1) / den;
            // m = 1 does not fit, saturate; the selector forces index 0 there anyway
            rom[m] = (q[2*RECIP_W-1:RECIP_W] != '0) ? '1 : q[RECIP_W-1:0];
        end
    end

    always_ff @(posedge clk_i) begin
        recip_o <= rom[addr_i];
        addr_q  <= addr_i;
    end

    assign recip_back = {{BUF_ADDR_W{1'b0}}, recip_o} * {{RECIP_W{1'b0}}, addr_q};

    // flag fires when the count drains into 0, not while it idles there
    assign zero_hit = (addr_i == '0) && !was_zero_q;

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            was_zero_q    <= 1'b1;  // count is 0 out of reset
            div_by_zero_o <= 1'b0;
        end else begin
            was_zero_q <= (addr_i == '0);
            if (clear_dbg_i) begin
                div_by_zero_o <= 1'b0;  // clear wins
            end else if (zero_hit) begin
                div_by_zero_o <= 1'b1;
            end
        end
    end

    // rounded up means recip * m sits in [2^RECIP_W, 2^RECIP_W + m)
    a_recip_ceil: assert property (@(posedge clk_i) disable iff (rst_i)
        (addr_q > BUF_ADDR_W'(1)) |->
            ((recip_back[RECIP_W+BUF_ADDR_W-1:RECIP_W] == BUF_ADDR_W'(1)) &&
             (recip_back[RECIP_W-1:0] < RECIP_W'(addr_q))))
        else $error("recip_table: entry 0x%0h is not the rounded-up reciprocal", addr_q);

endmodule

// ==== sat_pkg.sv ====
package sat_pkg;

    // clause geometry
    localparam int NSAT       = 3;                   // literals per clause
    localparam int LIT_ADDR_W = 12;                  // one literal address
    localparam int CLAUSE_W   = NSAT * LIT_ADDR_W;   // 36 bits

    // unsat clause buffer, depth must stay a power of two
    localparam int BUF_DEPTH  = 256;
    localparam int BUF_ADDR_W = $clog2(BUF_DEPTH);  // 8 bits

    // mod-m selection datapath
    localparam int RAND_W  = 18;  // external random number
    localparam int RECIP_W = 32;  // all fractional bits of 1/m

    // newly unsat clauses wait here
    localparam int FIFO_DEPTH = 8;
    localparam int FIFO_PTR_W = $clog2(FIFO_DEPTH);

    // one clause as three literal addresses
    typedef struct packed {
        logic [LIT_ADDR_W-1:0] lit0;
        logic [LIT_ADDR_W-1:0] lit1;
        logic [LIT_ADDR_W-1:0] lit2;
    } clause_t;

endpackage

// ==== tb_unsat_select.sv ====
`timescale 1ns/1ps

module tb_unsat_select;
    import sat_pkg::*;

    localparam int MAX_CYCLES = 4000;  // run needs roughly 500, plenty of margin

    logic                  clk_i;
    logic                  rst_i;
    logic                  setup_i;
    logic                  load_wr_en_i;
    logic [BUF_ADDR_W-1:0] load_addr_i;
    clause_t               load_clause_i;
    logic                  push_i;
    clause_t               push_clause_i;
    logic                  request_i;
    logic [RAND_W-1:0]     random_i;
    logic                  write_disable_i;
    logic                  clear_dbg_i;
    logic [BUF_ADDR_W-1:0] count_o;
    logic                  overflow_o;
    clause_t               selected_o;
    logic                  selected_valid_o;
    logic                  div_by_zero_o;
    logic                  fifo_full_o;

    // reference model
    clause_t shadow [BUF_DEPTH];  // mirror of the clause buffer
    int      shadow_cnt;
    clause_t pend_q [$];          // pushed, not yet in the buffer
    clause_t exp_q [$];           // expected selections in flight
    clause_t exp_c;
    integer  seed;
    int      errors;              // stimulus side
    int      chk_errors;          // checker side
    int      n_checks;
    int      cycles;

    unsat_select_top DUT (.*);

    initial begin
        clk_i = 1'b0;
        forever #10 clk_i = ~clk_i;
    end

    // mod m without any hardware trick, m = 1 always gives slot 0
    function automatic int expected_index(input int rnd, input int cnt);
        if (cnt <= 1) begin
            return 0;
        end
        return rnd % cnt;
    endfunction

    task automatic make_clause(output clause_t c);
        logic [31:0] r;
        r = $random(seed);
        c.lit0 = r[LIT_ADDR_W-1:0];
        r = $random(seed);
        c.lit1 = r[LIT_ADDR_W-1:0];
        r = $random(seed);
        c.lit2 = r[LIT_ADDR_W-1:0];
    endtask

    // called at a negedge
    task automatic check_status();
        if (count_o !== BUF_ADDR_W'(shadow_cnt)) begin
            $display("[FAIL] count_o: got 0x%0h expected 0x%0h", count_o, shadow_cnt);
            errors++;
        end
        if (overflow_o !== 1'b0) begin
            $display("[FAIL] overflow_o: got 0x%0h expected 0x0", overflow_o);
            errors++;
        end
    endtask

    // setup port writes slots 0..n-1 directly
    task automatic load_clauses(input int n);
        clause_t c;
        @(posedge clk_i);
        setup_i <= 1'b1;
        for (int i = 0; i < n; i++) begin
            make_clause(c);
            load_wr_en_i  <= 1'b1;
            load_addr_i   <= BUF_ADDR_W'(i);
            load_clause_i <= c;
            shadow[i] = c;
            @(posedge clk_i);
        end
        load_wr_en_i <= 1'b0;
        setup_i      <= 1'b0;
        shadow_cnt = n;
    endtask

    task automatic push_clauses(input int n);
        clause_t c;
        for (int i = 0; i < n; i++) begin
            make_clause(c);
            @(posedge clk_i);
            push_i        <= 1'b1;
            push_clause_i <= c;
            pend_q.push_back(c);
        end
        @(posedge clk_i);
        push_i <= 1'b0;
    endtask

    // idle cycles let the FIFO drain, then the model appends in push order
    task automatic append_pending(input int wait_n);
        repeat (wait_n) @(posedge clk_i);
        while (pend_q.size() > 0) begin
            shadow[shadow_cnt] = pend_q.pop_front();
            shadow_cnt++;
        end
        @(negedge clk_i);
        check_status();
    endtask

    // one request, optionally with a clause that reaches the FIFO at stage 3
    task automatic select_once(input logic with_push);
        logic [31:0]       r;
        logic [RAND_W-1:0] rnd;
        int                idx;
        clause_t           c;
        r   = $random(seed);
        rnd = r[RAND_W-1:0];
        c   = '0;
        idx = expected_index(int'(rnd), shadow_cnt);
        exp_q.push_back(shadow[idx]);
        if (with_push) begin
            make_clause(c);
            shadow[idx] = c;                      // FIFO head refills, count holds
        end else begin
            shadow[idx] = shadow[shadow_cnt-1];   // swap with last
            shadow_cnt--;
        end
        @(posedge clk_i);                         // edge 0
        request_i <= 1'b1;
        random_i  <= rnd;
        @(posedge clk_i);                         // edge 1
        request_i <= 1'b0;
        @(posedge clk_i);                         // edge 2
        if (with_push) begin
            push_i        <= 1'b1;
            push_clause_i <= c;
        end
        @(posedge clk_i);                         // edge 3
        push_i <= 1'b0;
        @(negedge clk_i);
        if (selected_valid_o !== 1'b0) begin
            $display("[FAIL] selected_valid_o: got 0x%0h expected 0x0 after 3 cycles",
                     selected_valid_o);
            errors++;
        end
        @(negedge clk_i);                         // after edge 4
        if (selected_valid_o !== 1'b1) begin
            $display("[FAIL] selected_valid_o: got 0x%0h expected 0x1 after 4 cycles",
                     selected_valid_o);
            errors++;
        end
        check_status();
        @(posedge clk_i);                         // edge 5, next request at 6
    endtask

    // compares every result the DUT presents
    always @(negedge clk_i) begin
        if (!rst_i && selected_valid_o) begin
            if (exp_q.size() == 0) begin
                $display("selected_valid_o high with no request in flight");
                chk_errors++;
            end else begin
                exp_c = exp_q.pop_front();
                n_checks++;
                if (selected_o !== exp_c) begin
                    $display("[FAIL] selected_o: got 0x%0h expected 0x%0h", selected_o, exp_c);
                    chk_errors++;
                end
            end
        end
    end

    // run limit
    always @(posedge clk_i) begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("timeout after %0d cycles, run did not finish", MAX_CYCLES);
            $display("TESTBENCH FAILED");
            $finish;
        end
    end

    initial begin
        seed            = 16;
        errors          = 0;
        chk_errors      = 0;
        n_checks        = 0;
        cycles          = 0;
        shadow_cnt      = 0;
        rst_i           = 1'b1;
        setup_i         = 1'b0;
        load_wr_en_i    = 1'b0;
        load_addr_i     = '0;
        load_clause_i   = '0;
        push_i          = 1'b0;
        push_clause_i   = '0;
        request_i       = 1'b0;
        random_i        = '0;
        write_disable_i = 1'b0;
        clear_dbg_i     = 1'b0;
        repeat (4) @(posedge clk_i);
        rst_i <= 1'b0;
        @(negedge clk_i);
        check_status();                           // count 0 out of reset
        if (selected_valid_o !== 1'b0) begin
            $display("[FAIL] selected_valid_o: got 0x%0h expected 0x0", selected_valid_o);
            errors++;
        end
        if (div_by_zero_o !== 1'b0) begin
            $display("[FAIL] div_by_zero_o: got 0x%0h expected 0x0", div_by_zero_o);
            errors++;
        end

        load_clauses(40);
        @(negedge clk_i);
        check_status();

        repeat (30) select_once(1'b0);            // FIFO empty, count 40 -> 10

        push_clauses(5);                          // idle appends
        append_pending(3);
        repeat (3) select_once(1'b1);             // refill from FIFO head

        // frozen buffer keeps clauses in the FIFO until it is full
        @(posedge clk_i);
        write_disable_i <= 1'b1;
        push_clauses(FIFO_DEPTH);
        repeat (4) @(posedge clk_i);
        @(negedge clk_i);
        check_status();
        if (fifo_full_o !== 1'b1) begin
            $display("[FAIL] fifo_full_o: got 0x%0h expected 0x1", fifo_full_o);
            errors++;
        end
        @(posedge clk_i);
        write_disable_i <= 1'b0;
        append_pending(FIFO_DEPTH + 1);           // one pop per cycle

        while (shadow_cnt > 1) begin
            select_once(1'b0);                    // drain down to one clause
        end
        repeat (3) select_once(1'b1);             // count 1, any random picks slot 0
        if (div_by_zero_o !== 1'b0) begin
            $display("[FAIL] div_by_zero_o: got 0x%0h expected 0x0", div_by_zero_o);
            errors++;
        end
        select_once(1'b0);                        // last clause out, count 0
        repeat (3) @(negedge clk_i);
        if (div_by_zero_o !== 1'b1) begin
            $display("[FAIL] div_by_zero_o: got 0x%0h expected 0x1", div_by_zero_o);
            errors++;
        end
        @(posedge clk_i);
        clear_dbg_i <= 1'b1;
        @(posedge clk_i);
        clear_dbg_i <= 1'b0;
        @(negedge clk_i);
        if (div_by_zero_o !== 1'b0) begin
            $display("[FAIL] div_by_zero_o: got 0x%0h expected 0x0", div_by_zero_o);
            errors++;
        end

        repeat (4) @(negedge clk_i);
        if (exp_q.size() != 0) begin
            $display("%0d selections never came out", exp_q.size());
            errors++;
        end
        $display("selections checked: %0d, errors: %0d", n_checks, errors + chk_errors);
        if (errors + chk_errors == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

// ==== unsat_clause_buffer.sv ====
`timescale 1ns/1ps

module unsat_clause_buffer (
    input  logic                           clk_i,
    // port A, read/write, read-first
    input  logic                           a_en_i,
    input  logic                           a_wr_en_i,
    input  logic [sat_pkg::BUF_ADDR_W-1:0] a_addr_i,
    input  sat_pkg::clause_t               a_data_i,
    output sat_pkg::clause_t               a_data_o,
    // port B, read only, always on
    input  logic [sat_pkg::BUF_ADDR_W-1:0] b_addr_i,
    output sat_pkg::clause_t               b_data_o
);
    import sat_pkg::*;

    clause_t mem [BUF_DEPTH];  // one unsat clause per slot

    // port A
    always_ff @(posedge clk_i) begin
        if (a_en_i) begin
            a_data_o <= mem[a_addr_i];  // old contents come out
            if (a_wr_en_i) begin
                mem[a_addr_i] <= a_data_i;
            end
        end
    end

    // port B tracks the last entry
    always_ff @(posedge clk_i) begin
        b_data_o <= mem[b_addr_i];
    end

endmodule

// ==== unsat_clause_selector.sv ====
`timescale 1ns/1ps

module unsat_clause_selector (
    input  logic                           clk_i,
    input  logic                           rst_i,
    // setup load
    input  logic                           setup_i,
    input  logic                           load_wr_en_i,
    input  logic [sat_pkg::BUF_ADDR_W-1:0] load_addr_i,
    input  sat_pkg::clause_t               load_clause_i,
    // controller
    input  logic                           request_i,      // one-cycle pulse
    input  logic [sat_pkg::RAND_W-1:0]     random_i,       // sampled with request_i
    input  logic                           write_disable_i,
    input  logic                           clear_dbg_i,
    // clause FIFO
    input  logic                           fifo_empty_i,
    input  sat_pkg::clause_t               fifo_head_i,
    output logic                           fifo_pop_o,
    // status and result
    output logic [sat_pkg::BUF_ADDR_W-1:0] count_o,
    output logic                           overflow_o,
    output sat_pkg::clause_t               selected_o,
    output logic                           selected_valid_o,
    output logic                           div_by_zero_o
);
    import sat_pkg::*;

    logic [BUF_ADDR_W:0]         count_q;     // msb is overflow
    logic [BUF_ADDR_W-1:0]       last_addr;
    logic                        buf_live;    // buffer may change this cycle
    // port A / port B
    logic                        a_en;
    logic                        a_wr_en;
    logic [BUF_ADDR_W-1:0]       a_addr;
    clause_t                     a_wdata;
    clause_t                     a_rdata;
    clause_t                     last_clause;
    logic [RECIP_W-1:0]          recip;
    // pipeline, NR mod m = NR - floor(NR * (1/m)) * m
    logic                        req_q1, req_q2, req_q3, req_q4;
    logic [RAND_W-1:0]           rand_q1, rand_q2;
    logic [BUF_ADDR_W-1:0]       count_q1, count_q2;
    logic [RAND_W+RECIP_W-1:0]   product_q2;
    logic [BUF_ADDR_W-1:0]       sel_q3;
    logic [RAND_W-1:0]           quot;
    logic [RAND_W-1:0]           count_ext;
    logic [RAND_W-1:0]           rem;
    logic [BUF_ADDR_W-1:0]       index_d;

    assign count_o    = count_q[BUF_ADDR_W-1:0];
    assign overflow_o = count_q[BUF_ADDR_W];
    assign last_addr  = count_q[BUF_ADDR_W-1:0] - 1'b1;
    assign buf_live   = ~setup_i & ~write_disable_i;
    assign fifo_pop_o = buf_live & ~fifo_empty_i;  // head goes into the buffer now

    // count register
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            count_q <= '0;
        end else if (setup_i) begin
            if (load_wr_en_i) begin
                count_q <= count_q + 1'b1;
            end
        end else if (!write_disable_i) begin
            if (!fifo_empty_i && !req_q3) begin
                count_q <= count_q + 1'b1;  // idle append
            end else if (fifo_empty_i && req_q3) begin
                count_q <= count_q - 1'b1;  // refilled from last, shrink
            end
            // refill from FIFO head keeps the count
        end
    end

    // request valid chain
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            req_q1 <= 1'b0;
            req_q2 <= 1'b0;
            req_q3 <= 1'b0;
            req_q4 <= 1'b0;
        end else begin
            req_q1 <= request_i;
            req_q2 <= req_q1;
            req_q3 <= req_q2;
            req_q4 <= req_q3;
        end
    end

    // index arithmetic
    assign quot      = product_q2[RAND_W+RECIP_W-1:RECIP_W];       // floor(NR / m)
    assign count_ext = {{(RAND_W-BUF_ADDR_W){1'b0}}, count_q2};
    assign rem       = rand_q2 - quot * count_ext;                 // exact, never wraps
    assign index_d   = (count_q2 == BUF_ADDR_W'(1)) ? '0 : rem[BUF_ADDR_W-1:0];

    always_ff @(posedge clk_i) begin
        // stage 1, table read lines up with count_q1
        rand_q1    <= random_i;
        count_q1   <= count_q[BUF_ADDR_W-1:0];
        // stage 2
        rand_q2    <= rand_q1;
        count_q2   <= count_q1;
        product_q2 <= {{RECIP_W{1'b0}}, rand_q1} * {{RAND_W{1'b0}}, recip};
        // stage 3
        sel_q3     <= index_d;
    end

    // port A mux
    always_comb begin
        a_en    = buf_live | setup_i | req_q3;  // selection read even when frozen
        a_wr_en = 1'b0;
        a_addr  = count_q[BUF_ADDR_W-1:0];      // idle: append slot
        a_wdata = fifo_empty_i ? last_clause : fifo_head_i;
        if (setup_i) begin
            a_wr_en = load_wr_en_i;
            a_addr  = load_addr_i;
            a_wdata = load_clause_i;
        end else if (req_q3) begin
            a_addr  = sel_q3;
            // no self copy when the selected slot is the last one
            a_wr_en = buf_live & (~fifo_empty_i | (sel_q3 != last_addr));
        end else begin
            a_wr_en = buf_live & ~fifo_empty_i;
        end
    end

    unsat_clause_buffer u_buffer (
        .clk_i     (clk_i),
        .a_en_i    (a_en),
        .a_wr_en_i (a_wr_en),
        .a_addr_i  (a_addr),
        .a_data_i  (a_wdata),
        .a_data_o  (a_rdata),
        .b_addr_i  (last_addr),
        .b_data_o  (last_clause)
    );

    recip_table u_recip (
        .clk_i         (clk_i),
        .rst_i         (rst_i),
        .addr_i        (count_q[BUF_ADDR_W-1:0]),
        .clear_dbg_i   (clear_dbg_i),
        .recip_o       (recip),
        .div_by_zero_o (div_by_zero_o)
    );

    // stage 4, read data of the selected slot
    assign selected_o       = a_rdata;
    assign selected_valid_o = req_q4;

    // holds only when the controller spaces requests
    a_index_in_range: assert property (@(posedge clk_i) disable iff (rst_i)
        req_q3 |-> ({1'b0, sel_q3} < count_q))
        else $error("selector: stage-3 index 0x%0h not below count 0x%0h", sel_q3, count_q);

    a_no_req_empty: assert property (@(posedge clk_i) disable iff (rst_i)
        request_i |-> (count_q != '0))
        else $error("selector: request with empty buffer");

endmodule

// ==== unsat_select_top.sv ====
`timescale 1ns/1ps

module unsat_select_top (
    input  logic                           clk_i,
    input  logic                           rst_i,
    input  logic                           setup_i,
    input  logic                           load_wr_en_i,
    input  logic [sat_pkg::BUF_ADDR_W-1:0] load_addr_i,
    input  sat_pkg::clause_t               load_clause_i,
    input  logic                           push_i,
    input  sat_pkg::clause_t               push_clause_i,
    input  logic                           request_i,
    input  logic [sat_pkg::RAND_W-1:0]     random_i,
    input  logic                           write_disable_i,
    input  logic                           clear_dbg_i,
    output logic [sat_pkg::BUF_ADDR_W-1:0] count_o,
    output logic                           overflow_o,
    output sat_pkg::clause_t               selected_o,
    output logic                           selected_valid_o,
    output logic                           div_by_zero_o,
    output logic                           fifo_full_o
);
    import sat_pkg::*;

    clause_t fifo_head;
    logic    fifo_empty;
    logic    fifo_pop;

    clause_fifo u_fifo (
        .clk_i       (clk_i),
        .rst_i       (rst_i),
        .push_i      (push_i),
        .push_data_i (push_clause_i),
        .pop_i       (fifo_pop),
        .head_o      (fifo_head),
        .empty_o     (fifo_empty),
        .full_o      (fifo_full_o)
    );

    unsat_clause_selector u_selector (
        .clk_i            (clk_i),
        .rst_i            (rst_i),
        .setup_i          (setup_i),
        .load_wr_en_i     (load_wr_en_i),
        .load_addr_i      (load_addr_i),
        .load_clause_i    (load_clause_i),
        .request_i        (request_i),
        .random_i         (random_i),
        .write_disable_i  (write_disable_i),
        .clear_dbg_i      (clear_dbg_i),
        .fifo_empty_i     (fifo_empty),
        .fifo_head_i      (fifo_head),
        .fifo_pop_o       (fifo_pop),
        .count_o          (count_o),
        .overflow_o       (overflow_o),
        .selected_o       (selected_o),
        .selected_valid_o (selected_valid_o),
        .div_by_zero_o    (div_by_zero_o)
    );

endmodule
